//--- rtl/ir_pkg.sv
// shared types and constants: command struct, symbol kinds, nec unit counts, key codes
`default_nettype none

package ir_pkg;

    // one queued command, user code in the upper byte
    typedef struct packed {
        logic [7:0] user;
        logic [7:0] data;
    } ir_cmd_t;

    // symbols the encoder can ask the timer for
    typedef enum logic [1:0] {
        SYM_LEADER,
        SYM_ZERO,
        SYM_ONE,
        SYM_STOP
    } sym_kind_t;

    // nec timing in 560 us units
    localparam logic [4:0] LEADER_MARK_UNITS  = 5'd16;  // 9 ms
    localparam logic [4:0] LEADER_SPACE_UNITS = 5'd8;   // 4.5 ms
    localparam logic [4:0] BIT_MARK_UNITS     = 5'd1;
    localparam logic [4:0] ZERO_SPACE_UNITS   = 5'd1;
    localparam logic [4:0] ONE_SPACE_UNITS    = 5'd3;
    localparam logic [4:0] STOP_MARK_UNITS    = 5'd1;

    // command bytes sent for each key
    localparam logic [7:0] KEY1_CODE = 8'h01;
    localparam logic [7:0] KEY2_CODE = 8'h02;

endpackage

`default_nettype wire

//--- rtl/ir_key_capture.sv
// key synchronizers, rising edge detection and command strobe generation
`timescale 1ns/1ps
`default_nettype none

module ir_key_capture import ir_pkg::*;
#(
    parameter logic [7:0] USER_CODE = 8'h00
)
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    key_1,
    input  logic    key_2,
    output logic    cmd_valid,
    output ir_cmd_t cmd
);

    logic [2:0] key_1_sr;   // [1:0] synchronizer, [2] edge reference
    logic [2:0] key_2_sr;
    logic       key_1_rise;
    logic       key_2_rise;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            key_1_sr <= 3'b000;
            key_2_sr <= 3'b000;
        end
        else
        begin
            key_1_sr <= {key_1_sr[1:0], key_1};
            key_2_sr <= {key_2_sr[1:0], key_2};
        end
    end

    assign key_1_rise = (key_1_sr[2:1] == 2'b01);
    assign key_2_rise = (key_2_sr[2:1] == 2'b01);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cmd_valid <= 1'b0;
        else
            cmd_valid <= key_1_rise | key_2_rise;   // one strobe per press
    end

    // key_1 wins when both rise together, key_2 is lost then
    always_ff @(posedge clk)
    begin
        if (key_1_rise || key_2_rise)
        begin
            cmd.user <= USER_CODE;
            cmd.data <= key_1_rise ? KEY1_CODE : KEY2_CODE;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ir_cmd_fifo.sv
// circular command FIFO with occupancy count, drops writes when full
`timescale 1ns/1ps
`default_nettype none

module ir_cmd_fifo import ir_pkg::*;
#(
    parameter int FIFO_DEPTH = 4    // power of two, at least 2
)
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cmd_valid,
    input  ir_cmd_t cmd,
    input  logic    pop,
    output ir_cmd_t rd_cmd,
    output logic    empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    ir_cmd_t       mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          wr_en;
    logic          rd_en;

    assign full  = (count == (AW+1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign wr_en = cmd_valid && !full;  // producer is never stalled
    assign rd_en = pop && !empty;

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= cmd;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rd_cmd = mem[rd_ptr];    // head entry, valid while not empty

endmodule

`default_nettype wire

//--- rtl/ir_nec_encoder.sv
// nec frame FSM: leader, four bytes LSB first and stop, issued as symbols
`timescale 1ns/1ps
`default_nettype none

module ir_nec_encoder import ir_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      empty,
    input  ir_cmd_t   rd_cmd,
    output logic      pop,
    output logic      busy,
    output logic      sym_start,
    output sym_kind_t sym_kind,
    input  logic      sym_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LEADER,
        ST_BYTES,
        ST_STOP
    } state_t;

    state_t     state;
    ir_cmd_t    cmd_q;
    logic [1:0] byte_idx;   // user, ~user, data, ~data
    logic [2:0] bit_idx;
    logic [1:0] next_byte;
    logic [2:0] next_bit;

    // symbol for one bit of the frame
    function automatic sym_kind_t bit_kind(input ir_cmd_t c, input logic [1:0] idx,
                                           input logic [2:0] pos);
        logic [7:0] frame_byte;
        case (idx)
            2'd0:    frame_byte = c.user;
            2'd1:    frame_byte = ~c.user;
            2'd2:    frame_byte = c.data;
            default: frame_byte = ~c.data;
        endcase
        return frame_byte[pos] ? SYM_ONE : SYM_ZERO;
    endfunction

    assign pop = (state == ST_IDLE) && !empty;

    assign next_bit  = bit_idx + 3'd1;
    assign next_byte = (bit_idx == 3'd7) ? byte_idx + 2'd1 : byte_idx;

    always_ff @(posedge clk)
    begin
        if (pop)
            cmd_q <= rd_cmd;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            byte_idx  <= 2'd0;
            bit_idx   <= 3'd0;
            busy      <= 1'b0;
            sym_start <= 1'b0;
            sym_kind  <= SYM_LEADER;
        end
        else
        begin
            sym_start <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (pop)
                    begin
                        state     <= ST_LEADER;
                        busy      <= 1'b1;
                        sym_start <= 1'b1;
                        sym_kind  <= SYM_LEADER;
                        byte_idx  <= 2'd0;
                        bit_idx   <= 3'd0;
                    end
                end
                ST_LEADER:
                begin
                    if (sym_done)
                    begin
                        state     <= ST_BYTES;
                        sym_start <= 1'b1;
                        sym_kind  <= bit_kind(cmd_q, 2'd0, 3'd0);   // first user bit
                    end
                end
                ST_BYTES:
                begin
                    if (sym_done)
                    begin
                        sym_start <= 1'b1;
                        if (bit_idx == 3'd7 && byte_idx == 2'd3)
                        begin
                            state    <= ST_STOP;
                            sym_kind <= SYM_STOP;
                        end
                        else
                        begin
                            byte_idx <= next_byte;
                            bit_idx  <= next_bit;
                            sym_kind <= bit_kind(cmd_q, next_byte, next_bit);
                        end
                    end
                end
                ST_STOP:
                begin
                    if (sym_done)
                    begin
                        state <= ST_IDLE;
                        busy  <= 1'b0;  // frame finished
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/ir_symbol_timer.sv
// symbol timer: mark and space timing per symbol, carrier generation and gating
`timescale 1ns/1ps
`default_nettype none

module ir_symbol_timer import ir_pkg::*;
#(
    parameter int UNIT_CYCLES    = 11200,
    parameter int CARRIER_CYCLES = 526
)
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sym_start,
    input  sym_kind_t sym_kind,
    output logic      sym_done,
    output logic      ir_out
);

    localparam int CW = $clog2(UNIT_CYCLES + 1);
    localparam int KW = $clog2(CARRIER_CYCLES + 1);

    logic [KW-1:0] car_cnt;
    logic          carrier;
    logic          active;
    logic [CW-1:0] cyc_cnt;     // cycle within the current unit
    logic [4:0]    unit_cnt;    // unit within the symbol
    logic [4:0]    mark_q;
    logic [4:0]    last_q;      // index of the final unit
    logic          unit_end;
    logic [4:0]    kind_mark;
    logic [4:0]    kind_space;
    logic          nxt_active;
    logic [CW-1:0] nxt_cyc;
    logic [4:0]    nxt_unit;
    logic [4:0]    nxt_mark;
    logic [4:0]    nxt_last;

    // free running carrier, high for the first half period
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            car_cnt <= '0;
        else if (car_cnt == KW'(CARRIER_CYCLES - 1))
            car_cnt <= '0;
        else
            car_cnt <= car_cnt + 1'b1;
    end

    assign carrier = (car_cnt < KW'(CARRIER_CYCLES / 2));

    always_comb
    begin
        case (sym_kind)
            SYM_LEADER:
            begin
                kind_mark  = LEADER_MARK_UNITS;
                kind_space = LEADER_SPACE_UNITS;
            end
            SYM_ZERO:
            begin
                kind_mark  = BIT_MARK_UNITS;
                kind_space = ZERO_SPACE_UNITS;
            end
            SYM_ONE:
            begin
                kind_mark  = BIT_MARK_UNITS;
                kind_space = ONE_SPACE_UNITS;
            end
            default:
            begin
                kind_mark  = STOP_MARK_UNITS;
                kind_space = 5'd0;      // stop is mark only
            end
        endcase
    end

    assign unit_end = (cyc_cnt == CW'(UNIT_CYCLES - 1));

    // position of the next cycle within the symbol
    always_comb
    begin
        nxt_active = active;
        nxt_cyc    = cyc_cnt;
        nxt_unit   = unit_cnt;
        nxt_mark   = mark_q;
        nxt_last   = last_q;
        if (sym_start)
        begin
            nxt_active = 1'b1;
            nxt_cyc    = '0;
            nxt_unit   = 5'd0;
            nxt_mark   = kind_mark;
            nxt_last   = kind_mark + kind_space - 5'd1;
        end
        else if (active)
        begin
            if (unit_end)
            begin
                nxt_cyc = '0;
                if (unit_cnt == last_q)
                    nxt_active = 1'b0;
                else
                    nxt_unit = unit_cnt + 5'd1;
            end
            else
                nxt_cyc = cyc_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active   <= 1'b0;
            cyc_cnt  <= '0;
            unit_cnt <= 5'd0;
            mark_q   <= 5'd0;
            last_q   <= 5'd0;
            ir_out   <= 1'b0;
            sym_done <= 1'b0;
        end
        else
        begin
            active   <= nxt_active;
            cyc_cnt  <= nxt_cyc;
            unit_cnt <= nxt_unit;
            mark_q   <= nxt_mark;
            last_q   <= nxt_last;
            ir_out   <= nxt_active && (nxt_unit < nxt_mark) && carrier;
            // high during the last cycle of the symbol
            sym_done <= nxt_active && (nxt_unit == nxt_last) &&
                        (nxt_cyc == CW'(UNIT_CYCLES - 1));
        end
    end

endmodule

`default_nettype wire

//--- rtl/ir_send_top.sv
// top level: key capture, command FIFO, nec encoder and symbol timer
`timescale 1ns/1ps
`default_nettype none

module ir_send_top import ir_pkg::*;
#(
    parameter int         UNIT_CYCLES    = 11200,   // 560 us at 20 MHz
    parameter int         CARRIER_CYCLES = 526,     // about 38 kHz at 20 MHz
    parameter logic [7:0] USER_CODE      = 8'h00,
    parameter int         FIFO_DEPTH     = 4
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic key_1,
    input  logic key_2,
    output logic ir_out,
    output logic busy
);

    logic      cmd_valid;
    ir_cmd_t   cmd;
    ir_cmd_t   rd_cmd;
    logic      empty;
    logic      pop;
    logic      sym_start;
    sym_kind_t sym_kind;
    logic      sym_done;

    ir_key_capture #(
        .USER_CODE (USER_CODE)
    ) i_key_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_1     (key_1),
        .key_2     (key_2),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    ir_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_cmd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .pop       (pop),
        .rd_cmd    (rd_cmd),
        .empty     (empty)
    );

    ir_nec_encoder i_nec_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (empty),
        .rd_cmd    (rd_cmd),
        .pop       (pop),
        .busy      (busy),
        .sym_start (sym_start),
        .sym_kind  (sym_kind),
        .sym_done  (sym_done)
    );

    ir_symbol_timer #(
        .UNIT_CYCLES    (UNIT_CYCLES),
        .CARRIER_CYCLES (CARRIER_CYCLES)
    ) i_symbol_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .sym_start (sym_start),
        .sym_kind  (sym_kind),
        .sym_done  (sym_done),
        .ir_out    (ir_out)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
// free running clock source for the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
    parameter int PERIOD_NS = 40
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;    // first rising edge at half a period
    end

endmodule

`default_nettype wire

//--- tests/tb_ir_send.sv
// nec transmitter testbench with key stimulus, envelope decoder, frame checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_ir_send import ir_pkg::*;
();

    localparam int          UNIT_CYCLES    = 16;
    localparam int          CARRIER_CYCLES = 4;
    localparam logic [7:0]  USER_CODE      = 8'hA5;
    localparam int          FIFO_DEPTH     = 2;
    localparam int          RESET_CYCLES   = 16;
    localparam int          QUIET_CYCLES   = 40;    // well past pop to leader start
    localparam int          BUSY_TIMEOUT   = 64;
    localparam logic [15:0] LFSR_SEED      = 16'd35;
    // longest frame is all ones plus one idle cycle per symbol
    localparam int FRAME_CYCLES = UNIT_CYCLES * (int'(LEADER_MARK_UNITS)
        + int'(LEADER_SPACE_UNITS) + 32 * (int'(BIT_MARK_UNITS) + int'(ONE_SPACE_UNITS))
        + int'(STOP_MARK_UNITS)) + 34;
    localparam int HOLD_CYCLES     = 3 * FRAME_CYCLES;
    localparam int TOTAL_FRAMES    = 8;             // frames expected over all tests
    localparam int WATCHDOG_CYCLES = 2 * (TOTAL_FRAMES * FRAME_CYCLES + HOLD_CYCLES);

    typedef enum logic [1:0] {PH_LEADER_MARK, PH_LEADER_SPACE, PH_BITS, PH_DONE} phase_t;

    logic        clk;
    logic        rst_n;
    logic        key_1;
    logic        key_2;
    logic        ir_out;
    logic        busy;
    logic [15:0] lfsr;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          start_errors;
    string       test_name;
    logic [31:0] exp_q[$];
    logic [31:0] got_q[$];      // decoded frames with the user byte in [7:0]

    // decoder state
    logic        in_mark;
    logic        busy_prev;
    int          mark_len;
    int          low_run;
    int          space_len;
    int          bit_count;
    logic [31:0] frame_bits;
    phase_t      phase;

    tb_clock #(
        .PERIOD_NS (40)
    ) i_clock (
        .clk (clk)
    );

    ir_send_top #(
        .UNIT_CYCLES    (UNIT_CYCLES),
        .CARRIER_CYCLES (CARRIER_CYCLES),
        .USER_CODE      (USER_CODE),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) i_ir_send_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .key_1  (key_1),
        .key_2  (key_2),
        .ir_out (ir_out),
        .busy   (busy)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic int to_units(input int cycles);
        return (cycles + UNIT_CYCLES / 2) / UNIT_CYCLES;   // nearest whole unit
    endfunction

    // bytes on air in order user, ~user, data and ~data
    function automatic logic [31:0] expected_frame(input logic [7:0] code);
        return {~code, code, ~USER_CODE, USER_CODE};
    endfunction

    task automatic take_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++)
        begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic value_fail(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        errors++;
        $display("Fail %s expected 0x%0h actual 0x%0h (%s)", test_name, expected, actual, what);
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic mark_ended(input int units);
        case (phase)
            PH_LEADER_MARK:
            begin
                assert (units == int'(LEADER_MARK_UNITS))
                else value_fail("leader mark units", int'(LEADER_MARK_UNITS), units);
                phase = PH_LEADER_SPACE;
            end
            PH_BITS:
            begin
                if (bit_count == 32)
                begin
                    assert (units == int'(STOP_MARK_UNITS))
                    else value_fail("stop mark units", int'(STOP_MARK_UNITS), units);
                    phase = PH_DONE;
                end
                else
                begin
                    assert (units == int'(BIT_MARK_UNITS))
                    else value_fail("bit mark units", int'(BIT_MARK_UNITS), units);
                end
            end
            default: note_error("a mark ended where the frame has no mark");
        endcase
    endtask

    // space_units is the space just finished
    task automatic mark_started(input int space_units);
        case (phase)
            PH_LEADER_MARK: frame_bits = '0;
            PH_LEADER_SPACE:
            begin
                assert (space_units == int'(LEADER_SPACE_UNITS))
                else value_fail("leader space units", int'(LEADER_SPACE_UNITS), space_units);
                phase     = PH_BITS;
                bit_count = 0;
            end
            PH_BITS:
            begin
                assert (space_units == int'(ONE_SPACE_UNITS) ||
                        space_units == int'(ZERO_SPACE_UNITS))
                else note_error($sformatf("a bit space of %0d units is neither zero nor one",
                                          space_units));
                // LSB first so each bit shifts down into place
                frame_bits = {space_units == int'(ONE_SPACE_UNITS), frame_bits[31:1]};
                bit_count++;
            end
            default: note_error("a mark started after the stop mark");
        endcase
    endtask

    task automatic frame_closed();
        if (in_mark)
        begin
            mark_ended(to_units(mark_len));    // stop mark closed by the fall of busy
            in_mark = 1'b0;
        end
        assert (phase == PH_DONE) else note_error("busy fell before a whole frame was sent");
        if (phase == PH_DONE)
            got_q.push_back(frame_bits);
        phase     = PH_LEADER_MARK;
        bit_count = 0;
        space_len = 0;
    endtask

    // envelope decoder sampled away from the active edge
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            in_mark   = 1'b0;
            busy_prev = 1'b0;
            mark_len  = 0;
            low_run   = 0;
            space_len = 0;
            bit_count = 0;
            phase     = PH_LEADER_MARK;
        end
        else
        begin
            if (ir_out)
            begin
                if (!in_mark)
                begin
                    mark_started(to_units(space_len));
                    in_mark  = 1'b1;
                    mark_len = 0;
                    low_run  = 0;
                end
                mark_len = mark_len + low_run + 1;
                low_run  = 0;
            end
            else if (in_mark)
            begin
                low_run++;
                if (low_run > CARRIER_CYCLES)  // longer than a carrier gap
                begin
                    mark_ended(to_units(mark_len));
                    in_mark   = 1'b0;
                    space_len = low_run;
                end
            end
            else
                space_len++;
            if (busy_prev && !busy)
                frame_closed();
            busy_prev = busy;
        end
    end

    task automatic drive_key(input int key_no, input logic level);
        if (key_no == 1)
            key_1 <= level;
        else
            key_2 <= level;
    endtask

    task automatic press_key(input int key_no);
        int width;
        int gap;
        take_bits(3, width);
        take_bits(3, gap);
        @(posedge clk);
        drive_key(key_no, 1'b1);
        repeat (4 + width) @(posedge clk);
        drive_key(key_no, 1'b0);
        repeat (4 + gap) @(posedge clk);
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            assert (ir_out == 1'b0) else value_fail("ir_out while idle", 0, ir_out);
            assert (busy == 1'b0) else value_fail("busy while idle", 0, busy);
        end
    endtask

    task automatic wait_busy();
        int waited;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!busy && waited < BUSY_TIMEOUT);
        assert (busy) else note_error("busy did not rise after a key press");
    endtask

    task automatic wait_frames(input int n);
        int waited;
        waited = 0;
        while (got_q.size() < n && waited < 2 * n * FRAME_CYCLES)
        begin
            @(posedge clk);
            waited++;
        end
        assert (got_q.size() >= n)
        else note_error($sformatf("only %0d of %0d frames arrived", got_q.size(), n));
    endtask

    task automatic check_frames();
        logic [31:0] exp;
        logic [31:0] got;
        repeat (QUIET_CYCLES) @(negedge clk);
        assert (busy == 1'b0) else note_error("a frame started after the expected ones");
        assert (got_q.size() == exp_q.size())
        else value_fail("frame count", exp_q.size(), got_q.size());
        while (exp_q.size() > 0 && got_q.size() > 0)
        begin
            exp = exp_q.pop_front();
            got = got_q.pop_front();
            assert (got == exp) else value_fail("frame", exp, got);
        end
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        start_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == start_errors)
            $display("test %s ok", test_name);
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - start_errors);
        end
    endtask

    initial
    begin
        rst_n        = 1'b0;
        key_1        = 1'b0;
        key_2        = 1'b0;
        lfsr         = LFSR_SEED;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        start_test("reset_quiet");
        check_quiet(RESET_CYCLES);
        @(posedge clk);
        rst_n <= 1'b1;
        check_quiet(2 * QUIET_CYCLES);
        finish_test();

        start_test("key1_frame");
        exp_q.push_back(expected_frame(KEY1_CODE));
        press_key(1);
        wait_frames(1);
        check_frames();
        finish_test();

        start_test("key2_frame");
        exp_q.push_back(expected_frame(KEY2_CODE));
        press_key(2);
        wait_frames(1);
        check_frames();
        finish_test();

        start_test("held_key");
        exp_q.push_back(expected_frame(KEY2_CODE));
        @(posedge clk);
        drive_key(2, 1'b1);
        repeat (HOLD_CYCLES) @(posedge clk);
        drive_key(2, 1'b0);
        wait_frames(1);
        check_frames();
        finish_test();

        start_test("queued_pair");
        exp_q.push_back(expected_frame(KEY1_CODE));
        exp_q.push_back(expected_frame(KEY2_CODE));
        press_key(1);
        wait_busy();
        press_key(2);       // lands inside the first frame
        wait_frames(2);
        check_frames();
        finish_test();

        // the first press is in flight and the next FIFO_DEPTH are queued while the rest drop
        start_test("fifo_overflow");
        exp_q.push_back(expected_frame(KEY1_CODE));
        exp_q.push_back(expected_frame(KEY2_CODE));
        exp_q.push_back(expected_frame(KEY1_CODE));
        press_key(1);
        wait_busy();
        press_key(2);
        press_key(1);
        press_key(2);
        press_key(2);
        wait_frames(1 + FIFO_DEPTH);
        check_frames();
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/ir_pkg.sv
rtl/ir_key_capture.sv
rtl/ir_cmd_fifo.sv
rtl/ir_nec_encoder.sv
rtl/ir_symbol_timer.sv
rtl/ir_send_top.sv
tests/tb_clock.sv
tests/tb_ir_send.sv

//--- Makefile
# Verilator lint, simulation and clean for the NEC IR transmitter

TOP := tb_ir_send

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module ir_send_top -f vlog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
